// File: hdl/serdes_params.svh
`ifndef SERDES_PARAMS_SVH
`define SERDES_PARAMS_SVH

// lane and word geometry
`define SERDES_NUM_LANES 4 // output lanes
`define SERDES_TX_DEPTH 8 // bit clocks per transmit word
`define SERDES_RX_DEPTH 4 // bit clocks per receive word

// input delay
`define SERDES_TAP_BITS 4 // tap counter width, wraps
`define SERDES_TAP_DEPTH (1 << `SERDES_TAP_BITS) // number of delay stages

// apb register map
`define SERDES_APB_AW 4 // address width
`define SERDES_APB_DW 32 // data width
`define SERDES_ADDR_CTRL 4'h0 // lane enables
`define SERDES_ADDR_DELAY 4'h4 // delay tap command / readback
`define SERDES_ADDR_RXWORD 4'h8 // last received word, read only

`endif

// File: hdl/serdes_pkg.sv
`include "serdes_params.svh"

package serdes_pkg;

	typedef logic [`SERDES_TX_DEPTH-1:0] tx_word_t; // one word per lane, sent msb first
	typedef logic [`SERDES_RX_DEPTH-1:0] rx_word_t; // deserialized input word
	typedef logic [`SERDES_TAP_BITS-1:0] tap_t; // input delay setting

	// CTRL view of a write
	typedef struct packed {
		logic [`SERDES_APB_DW-`SERDES_NUM_LANES-1:0] rsvd; // ignored
		logic [`SERDES_NUM_LANES-1:0] lane_enable; // one bit per lane
	} ctrl_fields_t;

	// DELAY view of a write
	typedef struct packed {
		logic [`SERDES_APB_DW-`SERDES_TAP_BITS-2:0] rsvd; // ignored
		logic inc_not_dec; // 1 adds, 0 subtracts
		tap_t steps; // how many taps to move
	} delay_cmd_t;

	// the same pwdata word, decoded by address
	typedef union packed {
		ctrl_fields_t ctrl_fields;
		delay_cmd_t delay_cmd;
	} cfg_word_u;

endpackage

// File: hdl/serdes_regs.sv
`include "serdes_params.svh"

module serdes_regs (
	input logic clock,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`SERDES_APB_AW-1:0] paddr,
	input logic [`SERDES_APB_DW-1:0] pwdata,
	input serdes_pkg::rx_word_t rx_word,
	output logic pready,
	output logic [`SERDES_APB_DW-1:0] prdata,
	output logic pslverr,
	output logic [`SERDES_NUM_LANES-1:0] lane_enable,
	output serdes_pkg::tap_t tap
);
	import serdes_pkg::*;

	cfg_word_u wdata; // pwdata seen through both register views
	logic access; // apb access phase
	logic addr_hit; // one of the three mapped registers
	logic wr_en;
	logic rd_en;

	assign wdata = pwdata;
	assign access = psel & penable;
	assign addr_hit = (paddr == `SERDES_ADDR_CTRL) ||
		(paddr == `SERDES_ADDR_DELAY) ||
		(paddr == `SERDES_ADDR_RXWORD);
	assign wr_en = access & pwrite & addr_hit; // unmapped writes do nothing
	assign rd_en = psel & ~pwrite; // read data valid through setup and access

	assign pready = 1'b1; // zero wait states
	assign pslverr = access & ~addr_hit; // error only in the access phase

	// control state
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			lane_enable <= '0; // all lanes off
			tap <= '0; // no extra delay, one register stage only
		end else if (wr_en) begin
			case (paddr)
				`SERDES_ADDR_CTRL: begin
					lane_enable <= wdata.ctrl_fields.lane_enable; // takes effect at next strobe
				end
				`SERDES_ADDR_DELAY: begin
					// tap wraps modulo 16 in both directions
					if (wdata.delay_cmd.inc_not_dec) begin
						tap <= tap + wdata.delay_cmd.steps;
					end else begin
						tap <= tap - wdata.delay_cmd.steps;
					end
				end
				default: begin
					// RXWORD is read only, write dropped without error
				end
			endcase
		end
	end

	// read mux, zero-extended fields
	always_comb begin
		prdata = '0;
		if (rd_en) begin
			case (paddr)
				`SERDES_ADDR_CTRL: begin
					prdata[`SERDES_NUM_LANES-1:0] = lane_enable;
				end
				`SERDES_ADDR_DELAY: begin
					prdata[`SERDES_TAP_BITS-1:0] = tap; // current tap, not the last command
				end
				`SERDES_ADDR_RXWORD: begin
					prdata[`SERDES_RX_DEPTH-1:0] = rx_word; // last captured word
				end
				default: begin
					prdata = '0; // unmapped reads return 0
				end
			endcase
		end
	end

	// host side protocol, penable only inside a selected transfer
	a_penable_needs_psel: assert property (
		@(posedge clock) disable iff (!rst_n)
		penable |-> psel
	);

endmodule

// File: hdl/word_strobe_gen.sv
`include "serdes_params.svh"

module word_strobe_gen (
	input logic clock,
	input logic rst_n,
	output logic word_strobe,
	output logic rx_strobe
);
	localparam int TX_CW = $clog2(`SERDES_TX_DEPTH); // mod 8 counter width
	localparam int RX_CW = $clog2(`SERDES_RX_DEPTH); // mod 4 counter width

	logic [TX_CW-1:0] tx_cnt; // bit position inside the transmit word
	logic [RX_CW-1:0] rx_cnt; // bit position inside the receive word

	// free running, both start at 0 so the first cycle after reset is a boundary
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			tx_cnt <= '0;
			rx_cnt <= '0;
		end else begin
			tx_cnt <= (tx_cnt == TX_CW'(`SERDES_TX_DEPTH - 1)) ? '0 : tx_cnt + 1'b1;
			rx_cnt <= (rx_cnt == RX_CW'(`SERDES_RX_DEPTH - 1)) ? '0 : rx_cnt + 1'b1;
		end
	end

	assign word_strobe = (tx_cnt == '0); // one cycle in 8, the divided strobe
	assign rx_strobe = (rx_cnt == '0); // one cycle in 4

	// a strobe is a single-cycle pulse
	a_strobe_single: assert property (
		@(posedge clock) disable iff (!rst_n)
		word_strobe |=> !word_strobe
	);

endmodule

// File: hdl/lane_serializer.sv
`include "serdes_params.svh"

module lane_serializer (
	input logic clock,
	input logic rst_n,
	input logic word_strobe,
	input logic enable,
	input serdes_pkg::tx_word_t word,
	output logic bit_out
);
	import serdes_pkg::*;

	tx_word_t shreg; // msb is on the pin

	// load at the end of the strobe cycle, shift left otherwise
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			shreg <= '0; // quiet lane out of reset
		end else if (word_strobe) begin
			if (enable) begin
				shreg <= word; // bit 7 appears on the next cycle
			end else begin
				shreg <= '0; // disabled lane ignores its word
			end
		end else begin
			shreg <= {shreg[`SERDES_TX_DEPTH-2:0], 1'b0}; // zero fill from the lsb
		end
	end

	// bits 7..0 leave over the 8 cycles after the strobe,
	// so bit 0 is out during the next strobe cycle
	assign bit_out = shreg[`SERDES_TX_DEPTH-1];

endmodule

// File: hdl/input_delay_line.sv
`include "serdes_params.svh"

module input_delay_line (
	input logic clock,
	input logic rst_n,
	input serdes_pkg::tap_t tap,
	input logic data_in,
	output logic data_out
);
	logic [`SERDES_TAP_DEPTH-1:0] dly_q; // dly_q[n] is data_in n+1 cycles ago

	// plain shift register, one stage per bit clock
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			dly_q <= '0; // flush so the receive word starts at 0
		end else begin
			dly_q <= {dly_q[`SERDES_TAP_DEPTH-2:0], data_in};
		end
	end

	// tap 0 is the input register alone, tap 15 the deepest stage
	assign data_out = dly_q[tap];

	// the select must be clean once out of reset
	a_tap_known: assert property (
		@(posedge clock) disable iff (!rst_n)
		!$isunknown(tap)
	);

endmodule

// File: hdl/lane_deserializer.sv
`include "serdes_params.svh"

module lane_deserializer (
	input logic clock,
	input logic rst_n,
	input logic rx_strobe,
	input logic bit_in,
	output serdes_pkg::rx_word_t rx_word
);
	import serdes_pkg::*;

	rx_word_t shreg; // last bits seen, newest in the lsb
	rx_word_t next_word; // shreg after this cycle's bit

	assign next_word = {shreg[`SERDES_RX_DEPTH-2:0], bit_in};

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			shreg <= '0;
			rx_word <= '0;
		end else begin
			shreg <= next_word; // shift every cycle
			if (rx_strobe) begin
				rx_word <= next_word; // earliest of the four in the msb
			end
		end
	end

endmodule

// File: hdl/oserdes_quad.sv
`include "serdes_params.svh"

module oserdes_quad (
	input logic clock,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`SERDES_APB_AW-1:0] paddr,
	input logic [`SERDES_APB_DW-1:0] pwdata,
	input serdes_pkg::tx_word_t word0,
	input serdes_pkg::tx_word_t word1,
	input serdes_pkg::tx_word_t word2,
	input serdes_pkg::tx_word_t word3,
	input logic data_in,
	output logic pready,
	output logic [`SERDES_APB_DW-1:0] prdata,
	output logic pslverr,
	output logic word_strobe,
	output logic [`SERDES_NUM_LANES-1:0] bit_out
);
	import serdes_pkg::*;

	logic [`SERDES_NUM_LANES-1:0] lane_enable; // from CTRL
	tap_t tap; // from DELAY
	logic rx_strobe; // receive word boundary
	logic delayed_bit; // data_in after tap+1 cycles
	rx_word_t rx_word; // back to RXWORD

	serdes_regs u_regs (
		.clock(clock), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.rx_word(rx_word),
		.pready(pready), .prdata(prdata), .pslverr(pslverr),
		.lane_enable(lane_enable), .tap(tap)
	);

	word_strobe_gen u_strobe (
		.clock(clock), .rst_n(rst_n), .word_strobe(word_strobe), .rx_strobe(rx_strobe)
	);

	// transmit lanes, all on the same strobe
	lane_serializer u_lane0 (.clock(clock), .rst_n(rst_n), .word_strobe(word_strobe),
		.enable(lane_enable[0]), .word(word0), .bit_out(bit_out[0]));
	lane_serializer u_lane1 (.clock(clock), .rst_n(rst_n), .word_strobe(word_strobe),
		.enable(lane_enable[1]), .word(word1), .bit_out(bit_out[1]));
	lane_serializer u_lane2 (.clock(clock), .rst_n(rst_n), .word_strobe(word_strobe),
		.enable(lane_enable[2]), .word(word2), .bit_out(bit_out[2]));
	lane_serializer u_lane3 (.clock(clock), .rst_n(rst_n), .word_strobe(word_strobe),
		.enable(lane_enable[3]), .word(word3), .bit_out(bit_out[3]));

	// receive path
	input_delay_line u_idelay (
		.clock(clock), .rst_n(rst_n), .tap(tap), .data_in(data_in), .data_out(delayed_bit)
	);

	lane_deserializer u_deser (
		.clock(clock), .rst_n(rst_n), .rx_strobe(rx_strobe), .bit_in(delayed_bit),
		.rx_word(rx_word)
	);

endmodule

// File: tb/tb_clock_gen.sv
module tb_clock_gen (
	output logic clock,
	output logic rst_n
);
	localparam int HALF_PERIOD = 2; // period 4
	localparam int RESET_CYCLES = 8; // rst_n low this many rising edges

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock; // free running bit clock
	end

	initial begin
		rst_n = 1'b0; // asserted from time 0
		repeat (RESET_CYCLES) @(posedge clock);
		rst_n <= 1'b1; // release on an edge, dut and model see the same edge
	end

endmodule

// File: tb/tb_oserdes_quad.sv
`include "serdes_params.svh"

module tb_oserdes_quad;
	import serdes_pkg::*;

	localparam int RESET_TIMEOUT = 64; // cycles to wait for rst_n
	localparam int STROBE_TIMEOUT = 2 * `SERDES_TX_DEPTH; // a strobe must come within two words

	logic clock;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`SERDES_APB_AW-1:0] paddr;
	logic [`SERDES_APB_DW-1:0] pwdata;
	tx_word_t word0;
	tx_word_t word1;
	tx_word_t word2;
	tx_word_t word3;
	logic data_in;
	logic pready;
	logic [`SERDES_APB_DW-1:0] prdata;
	logic pslverr;
	logic word_strobe;
	logic [`SERDES_NUM_LANES-1:0] bit_out;

	logic data_active; // random words and serial input running
	int unsigned error_count;
	int unsigned check_count;

	// model state, updated on every rising edge
	logic [3:0] m_lane_en;
	logic [3:0] m_tap;
	logic [2:0] m_tx_cnt; // position in the 8 bit word, 0 is the strobe cycle
	logic [1:0] m_rx_cnt; // position in the 4 bit receive frame
	tx_word_t m_lane_word [4]; // word each lane is sending
	logic [15:0] m_hist; // m_hist[n] is data_in sampled n+1 edges ago
	logic [3:0] m_window; // last four delayed bits, newest in the lsb
	logic [3:0] m_rx_word;

	tb_clock_gen u_clock_gen (.clock(clock), .rst_n(rst_n));

	oserdes_quad u_oserdes_quad (
		.clock(clock), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.word0(word0), .word1(word1), .word2(word2), .word3(word3), .data_in(data_in),
		.pready(pready), .prdata(prdata), .pslverr(pslverr),
		.word_strobe(word_strobe), .bit_out(bit_out)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why); // plain reason for the early end
		$display("checks run: %0d, errors: %0d", check_count, error_count);
		$display("STATUS: FAIL");
		$finish;
	endtask

	function automatic logic is_mapped(input logic [3:0] addr);
		return (addr == 4'h0) || (addr == 4'h4) || (addr == 4'h8); // CTRL, DELAY, RXWORD
	endfunction

	// register readback from the model, fields zero-extended
	function automatic logic [31:0] expected_read(input logic [3:0] addr);
		logic [31:0] value;
		value = '0;
		case (addr)
			4'h0: value[3:0] = m_lane_en;
			4'h4: value[3:0] = m_tap;
			4'h8: value[3:0] = m_rx_word;
			default: value = '0; // unmapped reads 0
		endcase
		return value;
	endfunction

	// lane bits for the current cycle, msb leaves first after the strobe edge
	function automatic logic [3:0] model_bits();
		logic [3:0] bits;
		logic [2:0] idx;
		idx = 3'd0 - m_tx_cnt; // tx_cnt 1 gives bit 7, tx_cnt 0 gives bit 0
		for (int l = 0; l < 4; l++) begin
			bits[l] = m_lane_word[l][idx];
		end
		return bits;
	endfunction

	// one rising edge, new random source data if running
	task automatic next_cycle();
		int unsigned r;
		@(posedge clock);
		if (data_active) begin
			r = $urandom();
			word0 <= r[7:0];
			word1 <= r[15:8];
			word2 <= r[23:16];
			word3 <= r[31:24];
			r = $urandom();
			data_in <= r[0];
		end
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
		input logic exp_err);
		next_cycle();
		psel <= 1'b1; // setup phase
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		next_cycle();
		penable <= 1'b1; // access phase
		@(negedge clock);
		check_value("write pready", 1'b1, pready);
		check_value("write pslverr", exp_err, pslverr);
		next_cycle(); // write lands on this edge
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, input string name,
		output logic [31:0] data);
		next_cycle();
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		pwdata <= '0;
		next_cycle();
		penable <= 1'b1;
		@(negedge clock); // prdata settled mid access phase
		check_value({name, " pready"}, 1'b1, pready);
		check_value({name, " pslverr"}, !is_mapped(addr), pslverr);
		check_value(name, expected_read(addr), prdata);
		data = prdata;
		next_cycle();
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic wait_for_reset();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (rst_n !== 1'b1) begin
			abort_run("reset was never released");
		end
	endtask

	// returns in the negedge of a strobe cycle
	task automatic wait_for_strobe();
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < STROBE_TIMEOUT) begin
			next_cycle();
			@(negedge clock);
			seen = (word_strobe === 1'b1);
			cycles++;
		end
		if (!seen) begin
			abort_run("word_strobe did not arrive in time");
		end
	endtask

	// cycle model of the serdes, reads inputs as they stood before the edge
	always @(posedge clock or negedge rst_n) begin : model_step
		logic delayed;
		if (!rst_n) begin
			m_lane_en = '0;
			m_tap = '0;
			m_tx_cnt = '0;
			m_rx_cnt = '0;
			for (int l = 0; l < 4; l++) begin
				m_lane_word[l] = '0;
			end
			m_hist = '0;
			m_window = '0;
			m_rx_word = '0;
		end else begin
			delayed = m_hist[m_tap]; // tap+1 cycles behind data_in
			if (m_tx_cnt == 3'd0) begin // word boundary, old enables apply
				m_lane_word[0] = m_lane_en[0] ? word0 : 8'h00;
				m_lane_word[1] = m_lane_en[1] ? word1 : 8'h00;
				m_lane_word[2] = m_lane_en[2] ? word2 : 8'h00;
				m_lane_word[3] = m_lane_en[3] ? word3 : 8'h00;
			end
			m_window = {m_window[2:0], delayed};
			if (m_rx_cnt == 2'd0) begin
				m_rx_word = m_window; // earliest bit in the msb
			end
			m_hist = {m_hist[14:0], data_in};
			m_tx_cnt = m_tx_cnt + 3'd1; // wraps mod 8
			m_rx_cnt = m_rx_cnt + 2'd1; // wraps mod 4
			if (psel && penable && pwrite) begin
				case (paddr)
					4'h0: m_lane_en = pwdata[3:0];
					4'h4: m_tap = pwdata[4] ? m_tap + pwdata[3:0] : m_tap - pwdata[3:0];
					default: ; // RXWORD and unmapped change nothing
				endcase
			end
		end
	end

	// continuous compare of the transmit side against the model
	always @(negedge clock) begin
		if (rst_n === 1'b1) begin
			check_value("model word_strobe", (m_tx_cnt == 3'd0), word_strobe);
			check_value("model bit_out", model_bits(), bit_out);
		end
	end

	initial begin : stimulus
		int unsigned r;
		logic [31:0] rd;
		logic [31:0] saved_ctrl;
		logic [31:0] saved_delay;
		logic [3:0] tap_track; // independent tap tracker for wraparound
		logic [3:0] addr;
		logic [3:0] en_at_strobe;
		logic [3:0] exp_bits;
		tx_word_t sent [4];

		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		word0 = '0;
		word1 = '0;
		word2 = '0;
		word3 = '0;
		data_in = 1'b0;
		data_active = 1'b0;
		error_count = 0;
		check_count = 0;
		r = $urandom(32'h9fc6_e69e); // seeds the generator for the whole run

		wait_for_reset();

		// reset state
		check_value("reset bit_out", '0, bit_out);
		read_reg(4'h0, "reset CTRL", rd);
		check_value("reset CTRL value", '0, rd);
		read_reg(4'h4, "reset DELAY", rd);
		check_value("reset DELAY value", '0, rd);
		read_reg(4'h8, "reset RXWORD", rd);
		check_value("reset RXWORD value", '0, rd);

		// serialization, lane enables change between words
		data_active = 1'b1;
		for (int round = 0; round < 8; round++) begin
			r = $urandom();
			write_reg(4'h0, r, 1'b0); // reserved bits random too
			read_reg(4'h0, "serial CTRL", rd);
			wait_for_strobe();
			en_at_strobe = r[3:0]; // enables as written
			sent[0] = word0; // words held during the strobe cycle
			sent[1] = word1;
			sent[2] = word2;
			sent[3] = word3;
			for (int k = 0; k < 8; k++) begin // 8 bits per word
				next_cycle();
				@(negedge clock);
				for (int l = 0; l < 4; l++) begin
					exp_bits[l] = en_at_strobe[l] ? sent[l][7-k] : 1'b0;
				end
				check_value("serial bit_out", exp_bits, bit_out);
			end
		end

		// delay commands with wraparound both ways
		tap_track = '0; // nothing has touched DELAY yet
		for (int i = 0; i < 24; i++) begin
			r = $urandom();
			write_reg(4'h4, r, 1'b0);
			tap_track = r[4] ? tap_track + r[3:0] : tap_track - r[3:0];
			read_reg(4'h4, "delay DELAY", rd);
			check_value("delay tap track", tap_track, rd[3:0]);
		end

		// receive path under random taps
		for (int i = 0; i < 20; i++) begin
			if (i % 5 == 0) begin
				r = $urandom();
				write_reg(4'h4, r, 1'b0); // new tap every few reads
			end
			r = $urandom_range(7, 0);
			repeat (r) next_cycle();
			read_reg(4'h8, "receive RXWORD", rd);
		end

		// unmapped addresses and the read-only RXWORD
		read_reg(4'h0, "unmapped CTRL before", rd);
		saved_ctrl = expected_read(4'h0);
		read_reg(4'h4, "unmapped DELAY before", rd);
		saved_delay = expected_read(4'h4);
		for (int i = 0; i < 10; i++) begin
			r = $urandom();
			addr = r[3:0];
			if (is_mapped(addr)) begin
				addr = addr | 4'h1; // 0, 4, 8 become 1, 5, 9
			end
			r = $urandom();
			write_reg(addr, r, 1'b1);
			read_reg(addr, "unmapped read", rd);
			check_value("unmapped read zero", '0, rd);
		end
		r = $urandom();
		write_reg(4'h8, r, 1'b0); // ignored, no error
		read_reg(4'h0, "unmapped CTRL after", rd);
		check_value("unmapped CTRL kept", saved_ctrl, rd);
		read_reg(4'h4, "unmapped DELAY after", rd);
		check_value("unmapped DELAY kept", saved_delay, rd);

		data_active = 1'b0;
		next_cycle();
		$display("checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hdl
hdl/serdes_pkg.sv
hdl/serdes_regs.sv
hdl/word_strobe_gen.sv
hdl/lane_serializer.sv
hdl/input_delay_line.sv
hdl/lane_deserializer.sv
hdl/oserdes_quad.sv
tb/tb_clock_gen.sv
tb/tb_oserdes_quad.sv

// File: Bender.yml
package:
  name: oserdes_quad

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/serdes_pkg.sv
      - hdl/serdes_regs.sv
      - hdl/word_strobe_gen.sv
      - hdl/lane_serializer.sv
      - hdl/input_delay_line.sv
      - hdl/lane_deserializer.sv
      - hdl/oserdes_quad.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_oserdes_quad.sv
